// ==== hdl/vdp_geom_pkg.sv ====
package vdp_geom_pkg;

    // ------------------------------
    // Coordinate widths
    // ------------------------------

    localparam int x_width = 10;
    localparam int y_width = 9;

    // ------------------------------
    // Raster geometry in pixel clocks
    // ------------------------------

    // The visible window sits in the top left corner of the scanned frame
    localparam int h_active = 64;
    localparam int v_active = 48;

    localparam int h_total  = 80;
    localparam int v_total  = 52;

    // ------------------------------
    // Sprites
    // ------------------------------

    localparam int sprite_width  = 8;
    localparam int sprite_height = 8;
    localparam int sprite_count  = 4;

    localparam int row_index_width    = 3;
    localparam int sprite_index_width = 2;

endpackage

// ==== hdl/vdp_reg_pkg.sv ====
package vdp_reg_pkg;

    // ------------------------------
    // Pixel format
    // ------------------------------

    localparam int rgb_width  = 3;
    localparam int ergb_width = 4;

    // Opaque flag sits above the colour bits
    localparam int ergb_opaque_bit = ergb_width - 1;

    // ------------------------------
    // Write port and register map
    // ------------------------------

    localparam int wr_data_width = 32;
    localparam int addr_width    = 7;

    // Addresses with this bit clear belong to the sprite register space
    localparam int sprite_space_bit = 6;

    // Sprite number and per-sprite register fields inside the address
    localparam int sprite_field_lsb = 4;
    localparam int reg_field_width  = 4;

    // Register 0 is xy, registers 8 to 15 are rows 0 to 7
    localparam int xy_reg      = 0;
    localparam int row_reg_bit = 3;

    localparam int bg_addr = 64;

    // ------------------------------
    // Sprite write word
    // ------------------------------

    localparam int xy_y_field_width = 10;
    localparam int xy_pad_width     = wr_data_width - 1 - xy_y_field_width
                                      - vdp_geom_pkg::x_width;

    // The same write word is either a position word or a row of pixels
    typedef union packed
    {
        struct packed
        {
            logic [xy_pad_width - 1:0]          pad;
            logic                               enable;
            logic [xy_y_field_width - 1:0]      y;
            logic [vdp_geom_pkg::x_width - 1:0] x;
        } xy;

        // Element 0 is the leftmost pixel on screen
        logic [vdp_geom_pkg::sprite_width - 1:0][ergb_width - 1:0] row;
    } sprite_word_t;

endpackage

// ==== hdl/vdp_timing.sv ====
`timescale 1ns/1ps

module vdp_timing
(
    input  logic                               clk,
    input  logic                               reset,

    output logic [vdp_geom_pkg::x_width - 1:0] pixel_x,
    output logic [vdp_geom_pkg::y_width - 1:0] pixel_y,
    output logic                               active
);

    // ------------------------------
    // Raster counters
    // ------------------------------

    logic line_end;
    logic frame_end;

    assign line_end  = pixel_x == vdp_geom_pkg::x_width'(vdp_geom_pkg::h_total - 1);
    assign frame_end = pixel_y == vdp_geom_pkg::y_width'(vdp_geom_pkg::v_total - 1);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            pixel_x <= '0;
        else if (line_end)
            pixel_x <= '0;
        else
            pixel_x <= pixel_x + 1'b1;
    end

    // The line counter steps once per horizontal wrap
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            pixel_y <= '0;
        else if (line_end)
        begin
            if (frame_end)
                pixel_y <= '0;
            else
                pixel_y <= pixel_y + 1'b1;
        end
    end

    // ------------------------------
    // Active window
    // ------------------------------

    assign active =    (pixel_x < vdp_geom_pkg::x_width'(vdp_geom_pkg::h_active))
                    && (pixel_y < vdp_geom_pkg::y_width'(vdp_geom_pkg::v_active));

    // The horizontal counter must wrap before it leaves the frame
    x_in_frame: assert property (
        @(posedge clk) disable iff (reset)
        pixel_x < vdp_geom_pkg::x_width'(vdp_geom_pkg::h_total)
    );

endmodule

// ==== hdl/vdp_reg_decoder.sv ====
`timescale 1ns/1ps

module vdp_reg_decoder
(
    input  logic                                       clk,
    input  logic                                       reset,

    input  logic                                       wr_en,
    input  logic [vdp_reg_pkg::addr_width - 1:0]       wr_addr,
    input  logic [vdp_reg_pkg::wr_data_width - 1:0]    wr_data,

    output logic [vdp_geom_pkg::sprite_count - 1:0]    xy_we,
    output logic [vdp_geom_pkg::sprite_count - 1:0]    row_we,
    output logic [vdp_geom_pkg::row_index_width - 1:0] row_index,

    output logic [vdp_reg_pkg::rgb_width - 1:0]        bg_rgb
);

    // ------------------------------
    // Address fields
    // ------------------------------

    logic                                          sprite_space;
    logic [vdp_geom_pkg::sprite_index_width - 1:0] sprite_sel;
    logic [vdp_reg_pkg::reg_field_width - 1:0]     reg_sel;

    assign sprite_space = !wr_addr[vdp_reg_pkg::sprite_space_bit];
    assign sprite_sel   = wr_addr[vdp_reg_pkg::sprite_field_lsb +:
                                  vdp_geom_pkg::sprite_index_width];
    assign reg_sel      = wr_addr[vdp_reg_pkg::reg_field_width - 1:0];

    // All sprites share the row number, only the strobe picks the sprite
    assign row_index = reg_sel[vdp_geom_pkg::row_index_width - 1:0];

    // ------------------------------
    // Write strobes
    // ------------------------------

    always_comb
    begin
        xy_we  = '0;
        row_we = '0;

        if (wr_en && sprite_space)
        begin
            if (reg_sel == vdp_reg_pkg::reg_field_width'(vdp_reg_pkg::xy_reg))
                xy_we[sprite_sel] = 1'b1;
            else if (reg_sel[vdp_reg_pkg::row_reg_bit])
                row_we[sprite_sel] = 1'b1;
        end
    end

    // Background colour register
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            bg_rgb <= '0;
        else if (wr_en && wr_addr == vdp_reg_pkg::addr_width'(vdp_reg_pkg::bg_addr))
            bg_rgb <= wr_data[vdp_reg_pkg::rgb_width - 1:0];
    end

    strobe_onehot: assert property (
        @(posedge clk) disable iff (reset) $onehot0({xy_we, row_we})
    );

endmodule

// ==== hdl/vdp_sprite.sv ====
`timescale 1ns/1ps

module vdp_sprite
(
    input  logic                                       clk,
    input  logic                                       reset,

    input  logic [vdp_geom_pkg::x_width - 1:0]         pixel_x,
    input  logic [vdp_geom_pkg::y_width - 1:0]         pixel_y,

    input  logic [vdp_reg_pkg::wr_data_width - 1:0]    wr_data,
    input  logic                                       xy_we,
    input  logic                                       row_we,
    input  logic [vdp_geom_pkg::row_index_width - 1:0] wr_row_index,

    output logic                                       rgb_en,
    output logic [vdp_reg_pkg::rgb_width - 1:0]        rgb
);

    // ------------------------------
    // Sprite state
    // ------------------------------

    logic                               sprite_en;
    logic [vdp_geom_pkg::x_width - 1:0] sprite_x;
    logic [vdp_geom_pkg::y_width - 1:0] sprite_y;

    logic [vdp_reg_pkg::wr_data_width - 1:0] rows [vdp_geom_pkg::sprite_height];

    vdp_reg_pkg::sprite_word_t wr_word;
    vdp_reg_pkg::sprite_word_t rd_word;

    assign wr_word = wr_data;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            sprite_en <= 1'b0;
        else if (xy_we)
            sprite_en <= wr_word.xy.enable;
    end

    // Only the low bits of the y field are kept
    always_ff @(posedge clk)
    begin
        if (xy_we)
        begin
            sprite_x <= wr_word.xy.x;
            sprite_y <= wr_word.xy.y[vdp_geom_pkg::y_width - 1:0];
        end
    end

    always_ff @(posedge clk)
    begin
        if (row_we)
            rows[wr_row_index] <= wr_word.row;
    end

    // ------------------------------
    // Hit test
    // ------------------------------

    // One extra bit keeps position plus 7 from wrapping past the coordinate range
    logic [vdp_geom_pkg::x_width:0] x_offset;
    logic [vdp_geom_pkg::x_width:0] x_last;
    logic [vdp_geom_pkg::y_width:0] y_offset;
    logic [vdp_geom_pkg::y_width:0] y_last;
    logic                           x_hit;
    logic                           y_hit;

    assign x_offset = {1'b0, pixel_x} - {1'b0, sprite_x};
    assign y_offset = {1'b0, pixel_y} - {1'b0, sprite_y};

    assign x_last = {1'b0, sprite_x}
                  + (vdp_geom_pkg::x_width + 1)'(vdp_geom_pkg::sprite_width - 1);
    assign y_last = {1'b0, sprite_y}
                  + (vdp_geom_pkg::y_width + 1)'(vdp_geom_pkg::sprite_height - 1);

    // A set top bit of the offset means the pixel lies before the sprite
    assign x_hit = !x_offset[vdp_geom_pkg::x_width] && ({1'b0, pixel_x} <= x_last);
    assign y_hit = !y_offset[vdp_geom_pkg::y_width] && ({1'b0, pixel_y} <= y_last);

    // ------------------------------
    // Pixel fetch
    // ------------------------------

    logic [$clog2(vdp_geom_pkg::sprite_width) - 1:0] col_sel;
    logic [vdp_geom_pkg::row_index_width - 1:0]      row_sel;
    logic [vdp_reg_pkg::ergb_width - 1:0]            pixel;

    assign col_sel = x_offset[$clog2(vdp_geom_pkg::sprite_width) - 1:0];
    assign row_sel = y_offset[vdp_geom_pkg::row_index_width - 1:0];
    assign rd_word = rows[row_sel];
    assign pixel   = rd_word.row[col_sel];

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            rgb_en <= 1'b0;
        else
            rgb_en <= sprite_en && x_hit && y_hit && pixel[vdp_reg_pkg::ergb_opaque_bit];
    end

    // Colour is only meaningful alongside rgb_en
    always_ff @(posedge clk)
    begin
        rgb <= pixel[vdp_reg_pkg::rgb_width - 1:0];
    end

    // A disabled sprite stays dark unless its enable bit was just written
    en_needs_sprite: assert property (
        @(posedge clk) disable iff (reset) !sprite_en && !$past(xy_we) |-> !rgb_en
    );

endmodule

// ==== hdl/vdp_mixer.sv ====
`timescale 1ns/1ps

module vdp_mixer
(
    input  logic                                       clk,
    input  logic                                       reset,

    input  logic                                       active,
    input  logic [vdp_geom_pkg::x_width - 1:0]         pixel_x,
    input  logic [vdp_geom_pkg::y_width - 1:0]         pixel_y,

    input  logic [vdp_geom_pkg::sprite_count - 1:0]    sprite_rgb_en,
    input  logic [vdp_geom_pkg::sprite_count * vdp_reg_pkg::rgb_width - 1:0]
                                                       sprite_rgb,

    input  logic [vdp_reg_pkg::rgb_width - 1:0]        bg_rgb,

    output logic                                       video_valid,
    output logic [vdp_geom_pkg::x_width - 1:0]         video_x,
    output logic [vdp_geom_pkg::y_width - 1:0]         video_y,
    output logic [vdp_reg_pkg::rgb_width - 1:0]        video_rgb
);

    // ------------------------------
    // Alignment with sprite outputs
    // ------------------------------

    logic                               active_d;
    logic [vdp_geom_pkg::x_width - 1:0] pixel_x_d;
    logic [vdp_geom_pkg::y_width - 1:0] pixel_y_d;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            active_d <= 1'b0;
        else
            active_d <= active;
    end

    always_ff @(posedge clk)
    begin
        pixel_x_d <= pixel_x;
        pixel_y_d <= pixel_y;
    end

    // ------------------------------
    // Priority selection
    // ------------------------------

    logic [vdp_reg_pkg::rgb_width - 1:0] mix_rgb;

    // Walking from the top index down lets sprite 0 win any overlap
    always_comb
    begin
        mix_rgb = bg_rgb;

        for (int i = vdp_geom_pkg::sprite_count - 1; i >= 0; i--)
        begin
            if (sprite_rgb_en[i])
                mix_rgb = sprite_rgb[i * vdp_reg_pkg::rgb_width +: vdp_reg_pkg::rgb_width];
        end
    end

    // ------------------------------
    // Output stage
    // ------------------------------

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            video_valid <= 1'b0;
            video_rgb   <= '0;
        end
        else
        begin
            video_valid <= active_d;
            video_rgb   <= active_d ? mix_rgb : '0;
        end
    end

    always_ff @(posedge clk)
    begin
        video_x <= pixel_x_d;
        video_y <= pixel_y_d;
    end

endmodule

// ==== hdl/vdp_top.sv ====
`timescale 1ns/1ps

module vdp_top
(
    input  logic                                    clk,
    input  logic                                    reset,

    input  logic                                    wr_en,
    input  logic [vdp_reg_pkg::addr_width - 1:0]    wr_addr,
    input  logic [vdp_reg_pkg::wr_data_width - 1:0] wr_data,

    output logic                                    video_valid,
    output logic [vdp_geom_pkg::x_width - 1:0]      video_x,
    output logic [vdp_geom_pkg::y_width - 1:0]      video_y,
    output logic [vdp_reg_pkg::rgb_width - 1:0]     video_rgb
);

    // ------------------------------
    // Internal wires
    // ------------------------------

    logic [vdp_geom_pkg::x_width - 1:0]         pixel_x;
    logic [vdp_geom_pkg::y_width - 1:0]         pixel_y;
    logic                                       active;

    logic [vdp_geom_pkg::sprite_count - 1:0]    xy_we;
    logic [vdp_geom_pkg::sprite_count - 1:0]    row_we;
    logic [vdp_geom_pkg::row_index_width - 1:0] row_index;
    logic [vdp_reg_pkg::rgb_width - 1:0]        bg_rgb;

    logic [vdp_geom_pkg::sprite_count - 1:0]    sprite_rgb_en;
    logic [vdp_geom_pkg::sprite_count * vdp_reg_pkg::rgb_width - 1:0] sprite_rgb;

    // ------------------------------
    // Instances
    // ------------------------------

    vdp_timing timing_inst
    (
        .clk       (clk),
        .reset     (reset),
        .pixel_x   (pixel_x),
        .pixel_y   (pixel_y),
        .active    (active)
    );

    vdp_reg_decoder decoder_inst
    (
        .clk       (clk),
        .reset     (reset),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .xy_we     (xy_we),
        .row_we    (row_we),
        .row_index (row_index),
        .bg_rgb    (bg_rgb)
    );

    // Each sprite sees the full write word and picks it up on its own strobe
    for (genvar i = 0; i < vdp_geom_pkg::sprite_count; i++)
    begin : sprite_gen
        vdp_sprite sprite_inst
        (
            .clk          (clk),
            .reset        (reset),
            .pixel_x      (pixel_x),
            .pixel_y      (pixel_y),
            .wr_data      (wr_data),
            .xy_we        (xy_we[i]),
            .row_we       (row_we[i]),
            .wr_row_index (row_index),
            .rgb_en       (sprite_rgb_en[i]),
            .rgb          (sprite_rgb[i * vdp_reg_pkg::rgb_width +: vdp_reg_pkg::rgb_width])
        );
    end

    vdp_mixer mixer_inst
    (
        .clk           (clk),
        .reset         (reset),
        .active        (active),
        .pixel_x       (pixel_x),
        .pixel_y       (pixel_y),
        .sprite_rgb_en (sprite_rgb_en),
        .sprite_rgb    (sprite_rgb),
        .bg_rgb        (bg_rgb),
        .video_valid   (video_valid),
        .video_x       (video_x),
        .video_y       (video_y),
        .video_rgb     (video_rgb)
    );

endmodule

// ==== bench/vdp_tb.sv ====
`timescale 1ns/1ps

module vdp_tb;

    localparam int frame_cycles   = vdp_geom_pkg::h_total * vdp_geom_pkg::v_total;
    localparam int timeout_cycles = 6 * frame_cycles + 1000;
    localparam int active_pixels  = vdp_geom_pkg::h_active * vdp_geom_pkg::v_active;

    logic                                    clk;
    logic                                    reset;
    logic                                    wr_en;
    logic [vdp_reg_pkg::addr_width - 1:0]    wr_addr;
    logic [vdp_reg_pkg::wr_data_width - 1:0] wr_data;

    logic                                    video_valid;
    logic [vdp_geom_pkg::x_width - 1:0]      video_x;
    logic [vdp_geom_pkg::y_width - 1:0]      video_y;
    logic [vdp_reg_pkg::rgb_width - 1:0]     video_rgb;

    vdp_top vdp_top_inst
    (
        .clk         (clk),
        .reset       (reset),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .video_valid (video_valid),
        .video_x     (video_x),
        .video_y     (video_y),
        .video_rgb   (video_rgb)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // ------------------------------
    // Reference model state
    // ------------------------------

    logic                                    model_en   [vdp_geom_pkg::sprite_count];
    int                                      model_x    [vdp_geom_pkg::sprite_count];
    int                                      model_y    [vdp_geom_pkg::sprite_count];
    logic [vdp_reg_pkg::wr_data_width - 1:0] model_rows [vdp_geom_pkg::sprite_count]
                                                        [vdp_geom_pkg::sprite_height];
    logic [vdp_reg_pkg::rgb_width - 1:0]     model_bg;

    int raster_x;
    int raster_y;
    int cycle_count;
    int valid_count;

    // Stage 1 holds the sprite result, stage 2 the final pixel as the DUT shows it
    logic                                stage1_active;
    int                                  stage1_x;
    int                                  stage1_y;
    logic [3:0]                          stage1_pix;
    logic                                stage2_valid;
    int                                  stage2_x;
    int                                  stage2_y;
    logic [vdp_reg_pkg::rgb_width - 1:0] stage2_rgb;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("error %s expected 0x%h actual 0x%h", name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "output mismatch");
        end
    endtask

    // Returns the opaque flag and colour of the lowest numbered opaque sprite
    function automatic logic [3:0] top_sprite_pixel(input int px, input int py);
        logic [3:0] result;
        logic [3:0] nibble;
        int         col;
        int         row;
        result = 4'h0;
        for (int s = 0; s < vdp_geom_pkg::sprite_count; s++)
        begin
            col = px - model_x[s];
            row = py - model_y[s];
            if (!result[3] && model_en[s] && col >= 0 && col < vdp_geom_pkg::sprite_width
                && row >= 0 && row < vdp_geom_pkg::sprite_height)
            begin
                nibble = model_rows[s][row][col * vdp_reg_pkg::ergb_width +: 4];
                if (nibble[3])
                    result = nibble;
            end
        end
        return result;
    endfunction

    function automatic void apply_write(input logic [6:0] addr, input logic [31:0] data);
        int s;
        int r;
        s = addr[5:4];
        r = addr[3:0];
        if (!addr[6])
        begin
            if (r == 0)
            begin
                model_en[s] = data[20];
                model_y[s]  = data[18:10];
                model_x[s]  = data[9:0];
            end
            else if (r >= 8)
                model_rows[s][r - 8] = data;
        end
        else if (addr == vdp_reg_pkg::bg_addr)
            model_bg = data[2:0];
    endfunction

    // ------------------------------
    // Model and output checks
    // ------------------------------

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles)
        begin
            $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display(">>> FAIL");
            $fatal(1, "timeout");
        end
        else if (reset)
        begin
            raster_x      = 0;
            raster_y      = 0;
            valid_count   = 0;
            model_bg      = '0;
            stage1_active = 1'b0;
            stage1_x      = 0;
            stage1_y      = 0;
            stage1_pix    = '0;
            stage2_valid  = 1'b0;
            stage2_x      = 0;
            stage2_y      = 0;
            stage2_rgb    = '0;
            for (int s = 0; s < vdp_geom_pkg::sprite_count; s++)
                model_en[s] = 1'b0;
        end
        else
        begin
            check_value("video_valid", stage2_valid, video_valid);
            check_value("video_rgb", stage2_rgb, video_rgb);
            if (stage2_valid)
            begin
                check_value("video_x", stage2_x, video_x);
                check_value("video_y", stage2_y, video_y);
            end
            if (video_valid)
                valid_count = valid_count + 1;
            if (stage2_x == vdp_geom_pkg::h_total - 1 && stage2_y == vdp_geom_pkg::v_total - 1)
            begin
                check_value("valid_count", active_pixels, valid_count);
                valid_count = 0;
            end

            // The background is taken one cycle later than the sprite state
            stage2_valid = stage1_active;
            stage2_x     = stage1_x;
            stage2_y     = stage1_y;
            if (!stage1_active)
                stage2_rgb = '0;
            else if (stage1_pix[3])
                stage2_rgb = stage1_pix[2:0];
            else
                stage2_rgb = model_bg;

            stage1_active = raster_x < vdp_geom_pkg::h_active
                            && raster_y < vdp_geom_pkg::v_active;
            stage1_x      = raster_x;
            stage1_y      = raster_y;
            stage1_pix    = top_sprite_pixel(raster_x, raster_y);

            if (wr_en)
                apply_write(wr_addr, wr_data);

            if (raster_x == vdp_geom_pkg::h_total - 1)
            begin
                raster_x = 0;
                raster_y = (raster_y == vdp_geom_pkg::v_total - 1) ? 0 : raster_y + 1;
            end
            else
                raster_x = raster_x + 1;
        end
    end

    // ------------------------------
    // Stimulus
    // ------------------------------

    task automatic write_reg(input logic [6:0] addr, input logic [31:0] data);
        @(posedge clk);
        wr_en   <= 1'b1;
        wr_addr <= addr;
        wr_data <= data;
        @(posedge clk);
        wr_en   <= 1'b0;
    endtask

    // Address and data keep toggling while the write enable is low
    task automatic wait_cycles(input int count);
        repeat (count)
        begin
            @(posedge clk);
            wr_addr <= $urandom;
            wr_data <= $urandom;
        end
    endtask

    function automatic logic [31:0] xy_word(input int x, input int y, input logic enable);
        logic [31:0] word;
        word        = $urandom;
        word[20]    = enable;
        word[18:10] = y[8:0];
        word[9:0]   = x[9:0];
        return word;
    endfunction

    task automatic load_sprites(input int x_lo, input int x_hi, input int y_lo, input int y_hi);
        for (int s = 0; s < vdp_geom_pkg::sprite_count; s++)
            for (int r = 0; r < vdp_geom_pkg::sprite_height; r++)
                write_reg({1'b0, s[1:0], 1'b1, r[2:0]}, $urandom);
        for (int s = 0; s < vdp_geom_pkg::sprite_count; s++)
            write_reg({1'b0, s[1:0], 4'h0},
                      xy_word($urandom_range(x_hi, x_lo), $urandom_range(y_hi, y_lo), 1'b1));
    endtask

    initial
    begin
        void'($urandom(32'hfc34_177f));
        cycle_count = 0;
        reset       = 1'b1;
        wr_en       = 1'b0;
        wr_addr     = '0;
        wr_data     = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // A full frame on the reset background
        wait_cycles(frame_cycles);

        repeat (8)
        begin
            write_reg(vdp_reg_pkg::bg_addr, $urandom);
            wait_cycles($urandom_range(300, 0));
        end

        // Clustered sprites overlap heavily in the middle of the screen
        load_sprites(20, 25, 14, 19);
        wait_cycles(frame_cycles);

        // Sprites hanging over the right and bottom edges
        load_sprites(58, 70, 42, 50);
        wait_cycles(frame_cycles);

        repeat (200)
        begin
            write_reg($urandom_range(127, 0), $urandom);
            wait_cycles($urandom_range(15, 0));
        end
        wait_cycles(frame_cycles);

        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== compile.f ====
hdl/vdp_geom_pkg.sv
hdl/vdp_reg_pkg.sv
hdl/vdp_timing.sv
hdl/vdp_reg_decoder.sv
hdl/vdp_sprite.sv
hdl/vdp_mixer.sv
hdl/vdp_top.sv
bench/vdp_tb.sv
